// ==== dv/cache_mem_trace.txt ====
# columns: test side(I/D/B) op(R/W) addr wdata expected, numbers in hex except the test
# a B line reads addr on both sides; wdata is the I-side line, expected the D-side line
#
# 1: data write, then data read of the same line
1 D W 00000100 a5a5a5a5000000010000000211111111 a5a5a5a5000000010000000211111111
1 D R 00000100 00000000000000000000000000000000 a5a5a5a5000000010000000211111111
#
# 2: instruction read of a fresh line, then of a line it wrote
2 I R 00000200 00000000000000000000000000000000 00000000000000000000000000000000
2 I W 00000240 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
2 I R 00000240 00000000000000000000000000000000 0123456789abcdeffedcba9876543210
#
# 3: the data region sits 0x800 above the instruction region
3 D W 00000080 c0dec0de22222222333333334444aaaa c0dec0de22222222333333334444aaaa
3 I R 00000880 00000000000000000000000000000000 c0dec0de22222222333333334444aaaa
3 I R 00000080 00000000000000000000000000000000 00000000000000000000000000000000
#
# 4: unaligned addresses return the whole aligned line
4 I R 0000024c 00000000000000000000000000000000 0123456789abcdeffedcba9876543210
4 D R 0000010a 00000000000000000000000000000000 a5a5a5a5000000010000000211111111
4 I R 0000088f 00000000000000000000000000000000 c0dec0de22222222333333334444aaaa
4 D R 00000087 00000000000000000000000000000000 c0dec0de22222222333333334444aaaa
#
# 5: both sides at once from idle, the instruction side answers first
5 I W 00000300 eeeeeeee0000000300000003eeeeeeee eeeeeeee0000000300000003eeeeeeee
5 D W 00000300 dddddddd0000000500000005dddddddd dddddddd0000000500000005dddddddd
5 B R 00000300 eeeeeeee0000000300000003eeeeeeee dddddddd0000000500000005dddddddd
5 B R 00000100 00000000000000000000000000000000 a5a5a5a5000000010000000211111111
5 B R 00000244 0123456789abcdeffedcba9876543210 00000000000000000000000000000000
#
# 6: lone requests at both ends of the storage, each answered after five cycles
6 I W 000007f0 f00df00d7777777788888888f00df00d f00df00d7777777788888888f00df00d
6 I R 000007fc 00000000000000000000000000000000 f00df00d7777777788888888f00df00d
6 D W 000007f4 99999999000000060000000699999999 99999999000000060000000699999999
6 D R 000007f0 00000000000000000000000000000000 99999999000000060000000699999999
6 I R 00000ff0 00000000000000000000000000000000 99999999000000060000000699999999
6 I R 00000000 00000000000000000000000000000000 00000000000000000000000000000000
6 D W 00000100 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
6 D R 00000104 00000000000000000000000000000000 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
6 I R 00000904 00000000000000000000000000000000 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
6 D R 000007ff 00000000000000000000000000000000 99999999000000060000000699999999

// ==== verilog.f ====
+incdir+common
common/mem_pkg.sv
arbiter/mem_arbiter.sv
hw/line_mem_ctrl.sv
hw/cache_mem_top.sv
dv/mem_checker.sv
dv/tb_cache_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_cache_mem -f verilog.f -o sim_cache_mem

output=$(./obj_dir/sim_cache_mem 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== dv/tb_cache_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module tb_cache_mem import mem_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 100;
    localparam int LONE_LATENCY   = 1 + `MEM_LATENCY;

    logic        clk_i;
    logic        rst_ni;
    addr_t       i_addr;
    logic        i_cs;
    line_t       i_wdata;
    logic        i_we;
    line_t       i_rdata;
    logic        i_rvalid;
    addr_t       d_addr;
    logic        d_cs;
    line_t       d_wdata;
    logic        d_we;
    line_t       d_rdata;
    logic        d_rvalid;
    logic        exp_valid;
    logic [15:0] exp_test;
    logic        exp_side;
    logic        exp_we;
    addr_t       exp_addr;
    line_t       exp_line;
    logic [7:0]  exp_lat;
    int          pass_cnt;
    int          fail_cnt;
    int          pending;
    int          n_expected;
    bit          timed_out;
    bit          trace_ok;

    always #2 clk_i = ~clk_i;

    cache_mem_top cache_mem_top_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .i_addr_i   (i_addr),
        .i_cs_i     (i_cs),
        .i_wdata_i  (i_wdata),
        .i_we_i     (i_we),
        .i_rdata_o  (i_rdata),
        .i_rvalid_o (i_rvalid),
        .d_addr_i   (d_addr),
        .d_cs_i     (d_cs),
        .d_wdata_i  (d_wdata),
        .d_we_i     (d_we),
        .d_rdata_o  (d_rdata),
        .d_rvalid_o (d_rvalid)
    );

    mem_checker mem_checker_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .i_cs_i      (i_cs),
        .i_rdata_i   (i_rdata),
        .i_rvalid_i  (i_rvalid),
        .d_cs_i      (d_cs),
        .d_rdata_i   (d_rdata),
        .d_rvalid_i  (d_rvalid),
        .exp_valid_i (exp_valid),
        .exp_test_i  (exp_test),
        .exp_side_i  (exp_side),
        .exp_we_i    (exp_we),
        .exp_addr_i  (exp_addr),
        .exp_line_i  (exp_line),
        .exp_lat_i   (exp_lat),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt),
        .pending_o   (pending)
    );

    // hands one expected response to the checker; side 0 is I, side 1 is D.
    task automatic push_expect(input int test, input logic side, input logic we,
                               input addr_t addr, input line_t line, input int lat);
        @(posedge clk_i);
        exp_valid <= 1'b1;
        exp_test  <= 16'(test);
        exp_side  <= side;
        exp_we    <= we;
        exp_addr  <= addr;
        exp_line  <= line;
        exp_lat   <= 8'(lat);
        n_expected++;
        @(posedge clk_i);
        exp_valid <= 1'b0;
    endtask

    task automatic start_request(input logic side, input logic we, input addr_t addr,
                                 input line_t wdata);
        if (side == 1'b0) begin
            i_addr  <= addr;
            i_we    <= we;
            i_wdata <= wdata;
            i_cs    <= 1'b1;
        end else begin
            d_addr  <= addr;
            d_we    <= we;
            d_wdata <= wdata;
            d_cs    <= 1'b1;
        end
    endtask

    // each side drops its select at the edge where it sees its read-valid pulse.
    task automatic wait_responses(input int test, input bit want_i, input bit want_d);
        bit got_i;
        bit got_d;
        int cycles;
        got_i  = !want_i;
        got_d  = !want_d;
        cycles = 0;
        while (!(got_i && got_d) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
            if (!got_i && i_rvalid) begin
                got_i = 1'b1;
                i_cs <= 1'b0;
            end
            if (!got_d && d_rvalid) begin
                got_d = 1'b1;
                d_cs <= 1'b0;
            end
        end
        if (!(got_i && got_d)) begin
            $display("test %0d got no read-valid pulse within %0d cycles", test, TIMEOUT_CYCLES);
            i_cs <= 1'b0;
            d_cs <= 1'b0;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_checks_done();
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        if (pending != 0) begin
            $display("%0d expected responses never reached the checker", pending);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_operation(input int test, input logic [7:0] side_c,
                                 input logic [7:0] op_c, input addr_t addr,
                                 input line_t wdata, input line_t expect_line);
        logic we;
        logic side;
        we   = (op_c == "W");
        side = (side_c == "D");
        if (side_c == "B" && op_c == "R") begin
            // B lines carry the I-side expected line in the write column.
            push_expect(test, 1'b0, 1'b0, addr, wdata, LONE_LATENCY);
            push_expect(test, 1'b1, 1'b0, addr, expect_line, 0);
            @(posedge clk_i);
            start_request(1'b0, 1'b0, addr, '0);
            start_request(1'b1, 1'b0, addr, '0);
            wait_responses(test, 1'b1, 1'b1);
        end else if ((side_c == "I" || side_c == "D") && (op_c == "R" || op_c == "W")) begin
            push_expect(test, side, we, addr, expect_line, LONE_LATENCY);
            @(posedge clk_i);
            start_request(side, we, addr, wdata);
            wait_responses(test, !side, side);
        end else begin
            $display("test %0d has an unknown side or operation in the trace", test);
            trace_ok = 1'b0;
        end
    endtask

    initial begin
        int         fd;
        int         code;
        int         fields;
        string      text_line;
        int         test;
        logic [7:0] side_c;
        logic [7:0] op_c;
        addr_t      addr;
        line_t      wdata;
        line_t      expect_line;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        i_addr     = '0;
        i_cs       = 1'b0;
        i_wdata    = '0;
        i_we       = 1'b0;
        d_addr     = '0;
        d_cs       = 1'b0;
        d_wdata    = '0;
        d_we       = 1'b0;
        exp_valid  = 1'b0;
        exp_test   = '0;
        exp_side   = 1'b0;
        exp_we     = 1'b0;
        exp_addr   = '0;
        exp_line   = '0;
        exp_lat    = '0;
        n_expected = 0;
        timed_out  = 1'b0;
        trace_ok   = 1'b1;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        fd = $fopen("dv/cache_mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/cache_mem_trace.txt");
            trace_ok = 1'b0;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(text_line, fd);
                if (code != 0 && text_line.len() > 1 && text_line[0] != "#") begin
                    fields = $sscanf(text_line, "%d %c %c %h %h %h", test, side_c, op_c,
                                     addr, wdata, expect_line);
                    if (fields != 6) begin
                        $display("could not parse trace line: %s", text_line);
                        trace_ok = 1'b0;
                    end else begin
                        run_operation(test, side_c, op_c, addr, wdata, expect_line);
                    end
                end
            end
            $fclose(fd);
        end

        if (!timed_out) begin
            wait_checks_done();
        end
        $display("%0d checks passed, %0d checks failed, %0d expected", pass_cnt, fail_cnt,
                 n_expected);
        if (fail_cnt == 0 && !timed_out && trace_ok && n_expected > 0
            && pass_cnt == n_expected) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mem_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_checker import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        i_cs_i,
    input  line_t       i_rdata_i,
    input  logic        i_rvalid_i,
    input  logic        d_cs_i,
    input  line_t       d_rdata_i,
    input  logic        d_rvalid_i,
    input  logic        exp_valid_i,
    input  logic [15:0] exp_test_i,
    input  logic        exp_side_i,
    input  logic        exp_we_i,
    input  addr_t       exp_addr_i,
    input  line_t       exp_line_i,
    input  logic [7:0]  exp_lat_i,
    output int          pass_cnt_o,
    output int          fail_cnt_o,
    output int          pending_o
);

    typedef struct packed {
        logic [15:0] test;
        logic        side;
        logic        we;
        addr_t       addr;
        line_t       line;
        logic [7:0]  lat;
    } expect_t;

    // responses come back one at a time, so the queue order is the answer order.
    expect_t exp_q[$];
    logic    i_cs_q;
    logic    d_cs_q;
    int      i_cycles;
    int      d_cycles;
    int      pass_cnt;
    int      fail_cnt;

    initial begin
        i_cs_q    = 1'b0;
        d_cs_q    = 1'b0;
        i_cycles  = 0;
        d_cycles  = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        pending_o = 0;
    end

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    task automatic check_response(input logic side, input line_t rdata, input int cycles);
        expect_t head;
        string   name;
        string   op;
        bit      ok;
        name = side ? "D" : "I";
        if (exp_q.size() == 0) begin
            $display("a response arrived on the %s side with no request outstanding", name);
            fail_cnt++;
        end else begin
            head = exp_q.pop_front();
            op   = head.we ? "write" : "read";
            ok   = 1'b1;
            if (head.side != side) begin
                $display("Error at %0t: test %0d expected the next response on the %s side",
                         $time, head.test, head.side ? "D" : "I");
                ok = 1'b0;
            end else if (rdata !== head.line) begin
                $display("Error at %0t: test %0d %s %s at %h returned %h, expected %h",
                         $time, head.test, name, op, head.addr, rdata, head.line);
                ok = 1'b0;
            end else if (head.lat != 0 && cycles != int'(head.lat)) begin
                $display("Error at %0t: test %0d read-valid came %0d cycles after select, %s",
                         $time, head.test, cycles, $sformatf("expected %0d", head.lat));
                ok = 1'b0;
            end
            if (ok) begin
                pass_cnt++;
                $display("test %0d: %s %s at %h passed", head.test, name, op, head.addr);
            end else begin
                fail_cnt++;
                $display("test %0d: %s %s at %h failed", head.test, name, op, head.addr);
            end
        end
    endtask

    always @(posedge clk_i) begin : sample
        expect_t entry;
        if (rst_ni) begin
            if (exp_valid_i) begin
                entry.test = exp_test_i;
                entry.side = exp_side_i;
                entry.we   = exp_we_i;
                entry.addr = exp_addr_i;
                entry.line = exp_line_i;
                entry.lat  = exp_lat_i;
                exp_q.push_back(entry);
            end
            // cycles are counted from the edge that first sees a select high.
            i_cycles = (i_cs_i && !i_cs_q) ? 0 : i_cycles + 1;
            d_cycles = (d_cs_i && !d_cs_q) ? 0 : d_cycles + 1;
            i_cs_q   = i_cs_i;
            d_cs_q   = d_cs_i;
            if (i_rvalid_i) begin
                check_response(1'b0, i_rdata_i, i_cycles);
            end
            if (d_rvalid_i) begin
                check_response(1'b1, d_rdata_i, d_cycles);
            end
        end
        pending_o <= exp_q.size();
    end

endmodule

`default_nettype wire

// ==== hw/cache_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_mem_top import mem_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,

    input  addr_t i_addr_i,
    input  logic  i_cs_i,
    input  line_t i_wdata_i,
    input  logic  i_we_i,
    output line_t i_rdata_o,
    output logic  i_rvalid_o,

    input  addr_t d_addr_i,
    input  logic  d_cs_i,
    input  line_t d_wdata_i,
    input  logic  d_we_i,
    output line_t d_rdata_o,
    output logic  d_rvalid_o
);

    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_we;
    logic  mem_cs;
    line_t mem_rdata;
    logic  mem_rvalid;
    logic  mem_hs;

    mem_arbiter mem_arbiter_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .i_addr_i     (i_addr_i),
        .i_cs_i       (i_cs_i),
        .i_wdata_i    (i_wdata_i),
        .i_we_i       (i_we_i),
        .i_rdata_o    (i_rdata_o),
        .i_rvalid_o   (i_rvalid_o),
        .d_addr_i     (d_addr_i),
        .d_cs_i       (d_cs_i),
        .d_wdata_i    (d_wdata_i),
        .d_we_i       (d_we_i),
        .d_rdata_o    (d_rdata_o),
        .d_rvalid_o   (d_rvalid_o),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .mem_cs_o     (mem_cs),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (mem_rvalid),
        .mem_hs_i     (mem_hs)
    );

    line_mem_ctrl line_mem_ctrl_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_we_i     (mem_we),
        .mem_cs_i     (mem_cs),
        .mem_hs_o     (mem_hs),
        .mem_rdata_o  (mem_rdata),
        .mem_rvalid_o (mem_rvalid)
    );

endmodule

`default_nettype wire

// ==== hw/line_mem_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module line_mem_ctrl import mem_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,

    input  addr_t mem_addr_i,
    input  line_t mem_wdata_i,
    input  logic  mem_we_i,
    input  logic  mem_cs_i,
    output logic  mem_hs_o,
    output line_t mem_rdata_o,
    output logic  mem_rvalid_o
);

    localparam int IDX_W = $clog2(`MEM_LINES);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    line_t             mem_q [`MEM_LINES];
    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [IDX_W-1:0]  idx_q;
    logic              we_q;
    line_t             wdata_q;
    logic [IDX_W-1:0]  req_idx;
    logic              accept;
    logic              done;

    assign req_idx = mem_addr_i[`LINE_OFFSET_BITS +: IDX_W];

    // A request is only taken while nothing is in flight.
    assign accept   = mem_cs_i && !busy_q;
    assign mem_hs_o = accept;

    assign done = busy_q && (cnt_q == CNT_W'(`MEM_LATENCY));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(1);
        end else if (done) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q  <= cnt_q + CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            idx_q   <= req_idx;
            we_q    <= mem_we_i;
            wdata_q <= mem_wdata_i;
        end
    end

    // writes land in the storage in the accepting cycle.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (accept && mem_we_i) begin
            mem_q[req_idx] <= mem_wdata_i;
        end
    end

    // a write answers with the line it stored.
    always_comb begin
        mem_rdata_o = '0;
        if (done) begin
            mem_rdata_o = we_q ? wdata_q : mem_q[idx_q];
        end
    end

    assign mem_rvalid_o = done;

endmodule

`default_nettype wire

// ==== arbiter/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module mem_arbiter import mem_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,

    input  addr_t i_addr_i,
    input  logic  i_cs_i,
    input  line_t i_wdata_i,
    input  logic  i_we_i,
    output line_t i_rdata_o,
    output logic  i_rvalid_o,

    input  addr_t d_addr_i,
    input  logic  d_cs_i,
    input  line_t d_wdata_i,
    input  logic  d_we_i,
    output line_t d_rdata_o,
    output logic  d_rvalid_o,

    output addr_t mem_addr_o,
    output line_t mem_wdata_o,
    output logic  mem_we_o,
    output logic  mem_cs_o,
    input  line_t mem_rdata_i,
    input  logic  mem_rvalid_i,
    input  logic  mem_hs_i
);

    grant_e state_q;
    grant_e state_d;
    logic   taken_q;
    addr_t  i_line_addr;
    addr_t  d_line_addr;

    assign i_line_addr = {i_addr_i[`ADDR_WIDTH-1:`LINE_OFFSET_BITS], {`LINE_OFFSET_BITS{1'b0}}};
    assign d_line_addr = {d_addr_i[`ADDR_WIDTH-1:`LINE_OFFSET_BITS], {`LINE_OFFSET_BITS{1'b0}}}
                         + addr_t'(`D_REGION_OFFSET);

    // the owner keeps the port while its select stays high.
    always_comb begin
        state_d = state_q;
        case (state_q)
            GRANT_IDLE: begin
                if (i_cs_i) begin
                    state_d = GRANT_I;
                end else if (d_cs_i) begin
                    state_d = GRANT_D;
                end
            end
            GRANT_I: begin
                if (!i_cs_i) begin
                    state_d = d_cs_i ? GRANT_D : GRANT_IDLE;
                end
            end
            GRANT_D: begin
                if (!d_cs_i) begin
                    state_d = i_cs_i ? GRANT_I : GRANT_IDLE;
                end
            end
            default: state_d = GRANT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= GRANT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Set once the memory takes the request, cleared by its answer.
    // Clearing on the answer lets the grant pass straight to the other side.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            taken_q <= 1'b0;
        end else if (mem_rvalid_i) begin
            taken_q <= 1'b0;
        end else if (mem_hs_i) begin
            taken_q <= 1'b1;
        end
    end

    always_comb begin
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        mem_we_o    = 1'b0;
        mem_cs_o    = 1'b0;
        i_rdata_o   = '0;
        i_rvalid_o  = 1'b0;
        d_rdata_o   = '0;
        d_rvalid_o  = 1'b0;
        case (state_q)
            GRANT_I: begin
                mem_addr_o  = i_line_addr;
                mem_wdata_o = i_wdata_i;
                mem_we_o    = i_we_i;
                mem_cs_o    = i_cs_i && !taken_q;
                i_rdata_o   = mem_rdata_i;
                i_rvalid_o  = mem_rvalid_i;
            end
            GRANT_D: begin
                mem_addr_o  = d_line_addr;
                mem_wdata_o = d_wdata_i;
                mem_we_o    = d_we_i;
                mem_cs_o    = d_cs_i && !taken_q;
                d_rdata_o   = mem_rdata_i;
                d_rvalid_o  = mem_rvalid_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

    // a byte address as seen by a requester or the memory.
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // one full cache line.
    typedef logic [`LINE_WIDTH-1:0] line_t;

    // owner of the memory port.
    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_I,
        GRANT_D
    } grant_e;

endpackage

`default_nettype wire

// ==== common/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address width of both requesters and the memory port.
`define ADDR_WIDTH 32

// one cache line, moved as a whole on every request.
`define LINE_WIDTH 128

// address bits that select a byte inside a line.
`define LINE_OFFSET_BITS 4

// Data-side requests land in the upper half of the storage.
`define D_REGION_OFFSET 32'h800

// lines held by the storage, indexed by address bits [11:4].
`define MEM_LINES 256

// cycles from the accepting handshake to the read-valid pulse.
`define MEM_LATENCY 4

`endif
